//--- host_wr.f
host_wr_pkg.sv
burst_splitter.sv
fence_gen.sv
irq_collector.sv
c1_tx_port.sv
host_wr_top.sv
host_wr_asserts.sv
tb_host_wr.sv

//--- run_sim.sh
#!/bin/sh
# build the design and testbench with Verilator, run it, then search the log
# for the pass line to decide the result
rm -f sim.log
verilator --binary --timing --assert --top-module tb_host_wr -f host_wr.f -o tb_host_wr_sim \
	&& ./obj_dir/tb_host_wr_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Done: no errors" sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tb_host_wr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_host_wr;
	import host_wr_pkg::*;

	localparam int NUM_TESTS   = 6;
	localparam int HALF_PERIOD = 10;

	logic               clk = 1'b0;
	logic               reset;
	logic               avmm_write;
	avmm_addr_t         avmm_address;
	line_data_t         avmm_writedata;
	burst_t             avmm_burstcount;
	logic               avmm_waitrequest;
	logic [1:0]         avmm_write_response;
	logic               avmm_write_responsevalid;
	logic [NUM_IRQ-1:0] irq;
	logic               tx_alm_full;
	c1_rx_t             c1rx;
	c1_tx_t             c1tx;

	// expected channel 1 beats in the order the host should see them
	c1_tx_t      exp_q[$];
	c1_tx_t      exp_beat;
	// tag that the next write or fence request should carry
	mdata_t      next_tag;
	logic [31:0] rng_state;
	int          mismatch_cnt = 0;
	int          unexpected_cnt = 0;
	int          lost_cnt = 0;
	int          resp_err_cnt = 0;
	int          assert_cnt;

	host_wr_top uut (
		.clk                      (clk),
		.reset                    (reset),
		.avmm_write               (avmm_write),
		.avmm_address             (avmm_address),
		.avmm_writedata           (avmm_writedata),
		.avmm_burstcount          (avmm_burstcount),
		.avmm_waitrequest         (avmm_waitrequest),
		.avmm_write_response      (avmm_write_response),
		.avmm_write_responsevalid (avmm_write_responsevalid),
		.irq                      (irq),
		.tx_alm_full              (tx_alm_full),
		.c1rx                     (c1rx),
		.c1tx                     (c1tx)
	);

	always #HALF_PERIOD clk = ~clk;

	// ************************************************************
	// stimulus helpers
	// ************************************************************

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	function automatic line_data_t random_line();
		line_data_t line;
		for (int w = 0; w < LINE_DATA_W / 32; w++)
			line[w*32 +: 32] = lcg_next();
		return line;
	endfunction

	// byte address of a cache line, optionally in the fence mirror
	function automatic avmm_addr_t line_addr(input cl_addr_t line, input logic fence);
		return {fence, line, 6'b000000};
	endfunction

	function automatic c1_tx_t make_beat(input req_type_e kind, input cl_len_e len,
		input logic sop, input cl_addr_t addr, input mdata_t tag, input line_data_t data);
		c1_tx_t beat;
		beat.valid        = 1'b1;
		beat.hdr.req_type = kind;
		beat.hdr.cl_len   = len;
		beat.hdr.sop      = sop;
		beat.hdr.address  = addr;
		beat.hdr.mdata    = tag;
		beat.data         = data;
		return beat;
	endfunction

	// queues the expected beats of one burst, then drives it beat by beat
	// a fence space address expects the fence first and then the plain write
	task automatic write_burst(input avmm_addr_t addr, input burst_t count);
		line_data_t data [4];
		cl_addr_t   start;
		logic       aligned;
		cl_len_e    len;
		start   = addr[CL_MSB:CL_LSB];
		aligned = (count == 3'd1) || (count == 3'd2 && !start[0]) ||
			(count == 3'd4 && start[1:0] == 2'b00);
		len = CL_LEN_1;
		if (aligned && count == 3'd2)
			len = CL_LEN_2;
		if (aligned && count == 3'd4)
			len = CL_LEN_4;
		if (addr[FENCE_BIT]) begin
			exp_q.push_back(make_beat(REQ_WRFENCE, CL_LEN_1, 1'b0, '0, next_tag, '0));
			next_tag++;
		end
		for (int b = 0; b < int'(count); b++) begin
			data[b] = random_line();
			exp_q.push_back(make_beat(REQ_WRLINE, len, !aligned || b == 0,
				start + cl_addr_t'(b), next_tag, data[b]));
			next_tag++;
		end
		// a beat counts as taken at the rising edge after waitrequest is seen low
		for (int b = 0; b < int'(count); b++) begin
			@(negedge clk);
			avmm_write      = 1'b1;
			avmm_address    = addr;
			avmm_writedata  = data[b];
			avmm_burstcount = count;
			#1;
			while (avmm_waitrequest) begin
				@(negedge clk);
				#1;
			end
		end
		@(negedge clk);
		avmm_write = 1'b0;
	endtask

	task automatic expect_irq(input irq_id_t line);
		exp_q.push_back(make_beat(REQ_INTR, CL_LEN_1, 1'b0, '0, mdata_t'(line), '0));
	endtask

	task automatic send_response(input rsp_type_e kind, input logic pulse);
		@(negedge clk);
		c1rx.rsp_valid = 1'b1;
		c1rx.resp_type = kind;
		c1rx.mdata     = mdata_t'(lcg_next());
		#1;
		assert (avmm_write_responsevalid == pulse && avmm_write_response == 2'b00)
			else begin
				resp_err_cnt++;
				$display("Mismatch at %0t: response kind %0h gave valid %0b code %0d, %s%0b",
					$time, kind, avmm_write_responsevalid, avmm_write_response,
					"expected code 0 and valid ", pulse);
			end
		@(negedge clk);
		c1rx.rsp_valid = 1'b0;
	endtask

	// ************************************************************
	// scoreboard
	// ************************************************************

	// channel 1 is registered, so its value is settled at the falling edge
	always @(negedge clk) begin
		if (c1tx.valid) begin
			if (exp_q.size() == 0) begin
				unexpected_cnt++;
				$display("Unexpected request on channel 1 at %0t with type %0h",
					$time, c1tx.hdr.req_type);
			end else begin
				exp_beat = exp_q.pop_front();
				assert (c1tx == exp_beat)
					else begin
						mismatch_cnt++;
						$display("Mismatch at %0t: got type %0h len %0h sop %0b addr %0h tag %0h",
							$time, c1tx.hdr.req_type, c1tx.hdr.cl_len, c1tx.hdr.sop,
							c1tx.hdr.address, c1tx.hdr.mdata);
						$display("  expected type %0h len %0h sop %0b addr %0h tag %0h, data ok %0b",
							exp_beat.hdr.req_type, exp_beat.hdr.cl_len, exp_beat.hdr.sop,
							exp_beat.hdr.address, exp_beat.hdr.mdata, c1tx.data == exp_beat.data);
					end
			end
		end
	end

	// ************************************************************
	// test sequence
	// ************************************************************

	initial begin
		rng_state       = 32'd22316;
		reset           = 1'b1;
		avmm_write      = 1'b0;
		avmm_address    = '0;
		avmm_writedata  = '0;
		avmm_burstcount = 3'd1;
		irq             = '0;
		tx_alm_full     = 1'b0;
		c1rx            = '0;
		next_tag        = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// aligned bursts go out as one multi line request each
		write_burst(line_addr(42'h10, 1'b0), 3'd1);
		write_burst(line_addr(42'h20, 1'b0), 3'd2);
		write_burst(line_addr(42'h40, 1'b0), 3'd4);
		// bursts of 3 and misaligned bursts are chopped into single lines
		write_burst(line_addr(42'h50, 1'b0), 3'd3);
		write_burst(line_addr(42'h61, 1'b0), 3'd2);
		write_burst(line_addr(42'h72, 1'b0), 3'd4);
		// fence mirror write, fence first and then the data
		write_burst(line_addr(42'h88, 1'b1), 3'd1);

		// three lines rise together and drain highest first, while a fence
		// and a burst wait behind them
		@(negedge clk);
		irq = 4'b1011;
		expect_irq(2'd3);
		expect_irq(2'd1);
		expect_irq(2'd0);
		write_burst(line_addr(42'h90, 1'b1), 3'd1);
		write_burst(line_addr(42'hA0, 1'b0), 3'd2);
		@(negedge clk);
		irq = '0;

		// almost full lands after the first beat and stalls the rest
		fork
			write_burst(line_addr(42'hC0, 1'b0), 3'd4);
			begin
				@(negedge clk);
				tx_alm_full = 1'b1;
				repeat (8) @(negedge clk);
				tx_alm_full = 1'b0;
			end
		join

		// only write line responses reach the avalon side
		send_response(RSP_WRLINE, 1'b1);
		send_response(RSP_WRFENCE, 1'b0);
		send_response(RSP_INTR, 1'b0);

		for (int i = 0; i < 40 && exp_q.size() != 0; i++)
			@(negedge clk);
		if (exp_q.size() != 0) begin
			lost_cnt = exp_q.size();
			$display("%0d expected requests never appeared on channel 1", lost_cnt);
		end

		assert_cnt = uut.u_asserts.fail_reset_valid + uut.u_asserts.fail_wait_after_reset +
			uut.u_asserts.fail_alm_full_write + uut.u_asserts.fail_irq_sop;
		$display("Errors: %0d mismatch, %0d unexpected, %0d lost, %0d response, %0d assertion",
			mismatch_cnt, unexpected_cnt, lost_cnt, resp_err_cnt, assert_cnt);
		if (mismatch_cnt + unexpected_cnt + lost_cnt + resp_err_cnt + assert_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// the limit gives every test 2000 ns
	initial begin
		#(NUM_TESTS * 2000);
		$display("Timeout: the run did not finish within %0d ns", NUM_TESTS * 2000);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- host_wr_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module host_wr_asserts (
	input logic                  clk,
	input logic                  reset,
	input logic                  avmm_waitrequest,
	input logic                  tx_alm_full,
	input host_wr_pkg::c1_tx_t   c1tx
);
	import host_wr_pkg::*;

	// one failure tally per property, each written by its own action block
	int fail_reset_valid = 0;
	int fail_wait_after_reset = 0;
	int fail_alm_full_write = 0;
	int fail_irq_sop = 0;

	// ************************************************************
	// reset behavior
	// ************************************************************

	// a clock edge under reset leaves the channel idle
	assert property (@(posedge clk) $past(reset) |-> !c1tx.valid)
		else begin
			fail_reset_valid++;
			$error("channel 1 valid right after a reset cycle");
		end

	// the ready register comes out of reset as not ready
	assert property (@(posedge clk) $fell(reset) |-> avmm_waitrequest)
		else begin
			fail_wait_after_reset++;
			$error("waitrequest low in the first cycle after reset");
		end

	// ************************************************************
	// channel rules
	// ************************************************************

	// waitrequest lags almost full by a cycle and the beat lags the grant by
	// one more, so two cycles of almost full rule out a write line beat
	assert property (@(posedge clk) disable iff (reset)
		$past(tx_alm_full) && $past(tx_alm_full, 2) |->
		!(c1tx.valid && c1tx.hdr.req_type == REQ_WRLINE))
		else begin
			fail_alm_full_write++;
			$error("write line request sent while almost full was held");
		end

	// interrupts are never the start of a data packet
	assert property (@(posedge clk) disable iff (reset)
		c1tx.valid && c1tx.hdr.req_type == REQ_INTR |-> !c1tx.hdr.sop)
		else begin
			fail_irq_sop++;
			$error("interrupt request with sop set");
		end

endmodule

bind host_wr_top host_wr_asserts u_asserts (
	.clk              (clk),
	.reset            (reset),
	.avmm_waitrequest (avmm_waitrequest),
	.tx_alm_full      (tx_alm_full),
	.c1tx             (c1tx)
);

`default_nettype wire

//--- host_wr_top.sv
`timescale 1ns/1ps
`default_nettype none

module host_wr_top (
	input  logic                            clk,
	input  logic                            reset,
	// avalon write master
	input  logic                            avmm_write,
	input  host_wr_pkg::avmm_addr_t         avmm_address,
	input  host_wr_pkg::line_data_t         avmm_writedata,
	input  host_wr_pkg::burst_t             avmm_burstcount,
	output logic                            avmm_waitrequest,
	output logic [1:0]                      avmm_write_response,
	output logic                            avmm_write_responsevalid,
	// interrupt lines
	input  logic [host_wr_pkg::NUM_IRQ-1:0] irq,
	// host channel 1
	input  logic                            tx_alm_full,
	input  host_wr_pkg::c1_rx_t             c1rx,
	output host_wr_pkg::c1_tx_t             c1tx
);
	import host_wr_pkg::*;

	// one request and one grant per source
	src_req_t wr_req;
	src_req_t fence_req;
	src_req_t irq_req;
	logic     wr_grant;
	logic     fence_grant;
	logic     irq_grant;
	logic     fence_hold;
	logic     irq_pending_any;

	// ************************************************************
	// request sources
	// ************************************************************

	burst_splitter u_burst (
		.clk             (clk),
		.reset           (reset),
		.avmm_write      (avmm_write),
		.avmm_address    (avmm_address),
		.avmm_writedata  (avmm_writedata),
		.avmm_burstcount (avmm_burstcount),
		.wr_grant        (wr_grant),
		.wr_req          (wr_req)
	);

	fence_gen u_fence (
		.clk          (clk),
		.reset        (reset),
		.avmm_write   (avmm_write),
		.avmm_address (avmm_address),
		.fence_grant  (fence_grant),
		.fence_req    (fence_req),
		.fence_hold   (fence_hold)
	);

	irq_collector u_irq (
		.clk             (clk),
		.reset           (reset),
		.irq             (irq),
		.irq_grant       (irq_grant),
		.irq_req         (irq_req),
		.irq_pending_any (irq_pending_any)
	);

	// shared transmit port
	c1_tx_port u_port (
		.clk                      (clk),
		.reset                    (reset),
		.wr_req                   (wr_req),
		.fence_req                (fence_req),
		.irq_req                  (irq_req),
		.fence_hold               (fence_hold),
		.irq_pending_any          (irq_pending_any),
		.tx_alm_full              (tx_alm_full),
		.c1rx                     (c1rx),
		.wr_grant                 (wr_grant),
		.fence_grant              (fence_grant),
		.irq_grant                (irq_grant),
		.avmm_waitrequest         (avmm_waitrequest),
		.avmm_write_responsevalid (avmm_write_responsevalid),
		.avmm_write_response      (avmm_write_response),
		.c1tx                     (c1tx)
	);

endmodule

`default_nettype wire

//--- c1_tx_port.sv
`timescale 1ns/1ps
`default_nettype none

module c1_tx_port (
	input  logic                  clk,
	input  logic                  reset,
	input  host_wr_pkg::src_req_t wr_req,
	input  host_wr_pkg::src_req_t fence_req,
	input  host_wr_pkg::src_req_t irq_req,
	input  logic                  fence_hold,
	input  logic                  irq_pending_any,
	input  logic                  tx_alm_full,
	input  host_wr_pkg::c1_rx_t   c1rx,
	output logic                  wr_grant,
	output logic                  fence_grant,
	output logic                  irq_grant,
	output logic                  avmm_waitrequest,
	output logic                  avmm_write_responsevalid,
	output logic [1:0]            avmm_write_response,
	output host_wr_pkg::c1_tx_t   c1tx
);
	import host_wr_pkg::*;

	// registered ready, taken from almost full and the interrupt state
	logic        avcmd_ready;
	// a fence went out and its data beat has not been taken yet
	logic        fence_sent;
	logic        fence_block;
	mdata_t      tx_mdata;
	src_req_t    sel_req;
	c1_req_hdr_t next_hdr;
	logic        any_grant;

	// ************************************************************
	// arbitration
	// ************************************************************

	// interrupts first but never into an almost full channel
	assign irq_grant   = irq_req.valid && !tx_alm_full;
	// fences may go out under almost full, the host always has room for one
	assign fence_grant = fence_req.valid && !fence_sent && !irq_grant;
	// after the fence is out its data beat is no longer held back
	assign fence_block = fence_hold && !fence_sent;

	// the pending term covers the first cycle of an interrupt, before the
	// registered ready has caught up with it
	assign avmm_waitrequest = !avcmd_ready || irq_pending_any || fence_block;
	assign wr_grant         = wr_req.valid && !avmm_waitrequest;
	assign any_grant        = irq_grant || fence_grant || wr_grant;

	// interrupts keep their line id, everything else gets the running tag
	always_comb begin
		if (irq_grant)
			sel_req = irq_req;
		else if (fence_grant)
			sel_req = fence_req;
		else
			sel_req = wr_req;
		next_hdr = sel_req.hdr;
		if (!irq_grant)
			next_hdr.mdata = tx_mdata;
	end

	// ************************************************************
	// registered channel
	// ************************************************************

	// the tag only counts requests that carry it, so write and fence tags stay dense
	always_ff @(posedge clk) begin
		c1tx.hdr  <= next_hdr;
		c1tx.data <= sel_req.data;
		if (reset) begin
			avcmd_ready <= 1'b0;
			fence_sent  <= 1'b0;
			tx_mdata    <= '0;
			c1tx.valid  <= 1'b0;
		end else begin
			avcmd_ready <= !tx_alm_full && !irq_pending_any;
			c1tx.valid  <= any_grant;
			if (fence_grant || wr_grant)
				tx_mdata <= tx_mdata + mdata_t'(1);
			if (fence_grant)
				fence_sent <= 1'b1;
			else if (wr_grant)
				fence_sent <= 1'b0;
		end
	end

	// only write line responses go back to avalon, fence and interrupt
	// responses stop here
	assign avmm_write_responsevalid = c1rx.rsp_valid && (c1rx.resp_type == RSP_WRLINE);
	assign avmm_write_response      = 2'b00;

endmodule

`default_nettype wire

//--- irq_collector.sv
`timescale 1ns/1ps
`default_nettype none

module irq_collector (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [host_wr_pkg::NUM_IRQ-1:0]   irq,
	input  logic                              irq_grant,
	output host_wr_pkg::src_req_t             irq_req,
	output logic                              irq_pending_any
);
	import host_wr_pkg::*;

	// last sampled level of each line, used to find rising edges
	logic [NUM_IRQ-1:0] irq_prev;
	// one bit per line that still owes an interrupt request
	logic [NUM_IRQ-1:0] pending;

	logic [NUM_IRQ-1:0] rise;
	logic [NUM_IRQ-1:0] sent_mask;
	irq_id_t            sel_id;

	assign rise = irq & ~irq_prev;

	// ************************************************************
	// line selection
	// ************************************************************

	// scan upward so the highest pending line is the one left in sel_id
	always_comb begin
		sel_id = '0;
		for (int j = 0; j < NUM_IRQ; j++) begin
			if (pending[j])
				sel_id = irq_id_t'(j);
		end
	end

	// the grant is for whatever line was offered this cycle
	assign sent_mask = irq_grant ? (NUM_IRQ'(1) << sel_id) : '0;

	// a new edge on the line that is being granted is kept rather than lost,
	// so the set term is applied after the clear
	always_ff @(posedge clk) begin
		if (reset) begin
			irq_prev <= '0;
			pending  <= '0;
		end else begin
			irq_prev <= irq;
			pending  <= (pending & ~sent_mask) | rise;
		end
	end

	assign irq_pending_any = |pending;

	// ************************************************************
	// request header
	// ************************************************************

	// interrupt requests carry no address and no sop, the line id rides in
	// the low mdata bits and the port leaves it alone
	always_comb begin
		irq_req.valid        = irq_pending_any;
		irq_req.hdr.req_type = REQ_INTR;
		irq_req.hdr.cl_len   = CL_LEN_1;
		irq_req.hdr.sop      = 1'b0;
		irq_req.hdr.address  = '0;
		irq_req.hdr.mdata    = mdata_t'(sel_id);
		irq_req.data         = '0;
	end

endmodule

`default_nettype wire

//--- fence_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fence_gen (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    avmm_write,
	input  host_wr_pkg::avmm_addr_t avmm_address,
	input  logic                    fence_grant,
	output host_wr_pkg::src_req_t   fence_req,
	output logic                    fence_hold
);
	import host_wr_pkg::*;

	// a write is aimed at the fence mirror when address bit 48 is set
	logic fence_space;
	// high in the cycle after the fence went out
	logic fence_done;

	assign fence_space = avmm_write && avmm_address[FENCE_BIT];

	// ************************************************************
	// fence sequencing
	// ************************************************************

	// once the fence is granted the same beat must not ask again
	// from then on the port keeps track of the data beat until it is taken
	always_ff @(posedge clk) begin
		if (reset)
			fence_done <= 1'b0;
		else
			fence_done <= fence_grant;
	end

	// the data of a fence write is held back until the fence itself is gone
	assign fence_hold = fence_space && !fence_done;

	// the fence header has no address, the data beat carries it instead
	always_comb begin
		fence_req.valid        = fence_hold;
		fence_req.hdr.req_type = REQ_WRFENCE;
		fence_req.hdr.cl_len   = CL_LEN_1;
		fence_req.hdr.sop      = 1'b0;
		fence_req.hdr.address  = '0;
		fence_req.hdr.mdata    = '0;
		fence_req.data         = '0;
	end

endmodule

`default_nettype wire

//--- burst_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module burst_splitter (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    avmm_write,
	input  host_wr_pkg::avmm_addr_t avmm_address,
	input  host_wr_pkg::line_data_t avmm_writedata,
	input  host_wr_pkg::burst_t     avmm_burstcount,
	input  logic                    wr_grant,
	output host_wr_pkg::src_req_t   wr_req
);
	import host_wr_pkg::*;

	// beats still to come after the current one, zero means a first beat is next
	logic [1:0] beat_cnt;
	// line address of the next non-first beat
	cl_addr_t   line_cnt;
	// set for the remaining beats of a burst that is being chopped
	logic       chop_rest;
	// line count sent with the remaining beats of an aligned burst
	cl_len_e    len_rest;

	logic       first_beat;
	logic       unaligned;
	cl_len_e    len_first;
	cl_addr_t   start_line;
	burst_t     burst_rem;

	assign first_beat = (beat_cnt == 2'd0);
	// bit 48 falls away here, so fence space writes land in normal host space
	assign start_line = avmm_address[CL_MSB:CL_LSB];
	assign burst_rem  = avmm_burstcount - burst_t'(1);

	// ************************************************************
	// alignment check on the first beat
	// ************************************************************

	// a burst of 4 has to start on a 4 line boundary and a burst of 2 on a
	// 2 line boundary, otherwise the host cannot take it as one request
	// a burst of 3 has no multi line encoding at all
	assign unaligned = ((avmm_burstcount == 3'd4) && (start_line[1:0] != 2'b00)) ||
		((avmm_burstcount == 3'd2) && start_line[0]) ||
		(avmm_burstcount == 3'd3);

	// anything chopped goes out as single lines
	always_comb begin
		len_first = CL_LEN_1;
		if (!unaligned) begin
			case (avmm_burstcount)
				3'd2:    len_first = CL_LEN_2;
				3'd4:    len_first = CL_LEN_4;
				default: len_first = CL_LEN_1;
			endcase
		end
	end

	// ************************************************************
	// beat and address counters
	// ************************************************************

	// the counter only moves on a beat the port actually took
	// burstcount is only trusted on the first beat, so the chop decision is
	// held in chop_rest for the rest of the burst
	always_ff @(posedge clk) begin
		if (reset) begin
			beat_cnt  <= 2'd0;
			chop_rest <= 1'b0;
		end else if (wr_grant) begin
			if (first_beat) begin
				beat_cnt  <= burst_rem[1:0];
				chop_rest <= unaligned;
			end else begin
				beat_cnt <= beat_cnt - 2'd1;
			end
		end
	end

	// line address and line count for the following beats
	// the first beat loads start plus one since the counter is only read after it
	always_ff @(posedge clk) begin
		if (wr_grant && first_beat) begin
			line_cnt <= start_line + cl_addr_t'(1);
			len_rest <= len_first;
		end else if (wr_grant) begin
			line_cnt <= line_cnt + cl_addr_t'(1);
		end
	end

	// ************************************************************
	// request header
	// ************************************************************

	// the request just mirrors the avalon beat, the port decides when it goes
	// a chopped burst marks every beat as the start of its own packet
	always_comb begin
		wr_req.valid        = avmm_write;
		wr_req.hdr.req_type = REQ_WRLINE;
		wr_req.hdr.cl_len   = first_beat ? len_first : len_rest;
		wr_req.hdr.sop      = first_beat || chop_rest;
		wr_req.hdr.address  = first_beat ? start_line : line_cnt;
		// tag comes from the port
		wr_req.hdr.mdata    = '0;
		wr_req.data         = avmm_writedata;
	end

endmodule

`default_nettype wire

//--- host_wr_pkg.sv
`default_nettype none

package host_wr_pkg;

	// ************************************************************
	// widths and counts
	// ************************************************************

	// avalon side byte address, the top bit selects the fence mirror
	localparam int AVMM_ADDR_W = 49;
	localparam int FENCE_BIT   = 48;

	// a cache line is 64 bytes so the line address drops the low 6 bits
	localparam int CL_LSB    = 6;
	localparam int CL_MSB    = 47;
	localparam int CL_ADDR_W = CL_MSB - CL_LSB + 1;

	localparam int LINE_DATA_W = 512;
	localparam int BURST_W     = 3;
	localparam int MDATA_W     = 16;

	// interrupt lines and the bits needed to name one of them
	localparam int NUM_IRQ  = 4;
	localparam int IRQ_ID_W = $clog2(NUM_IRQ);

	typedef logic [AVMM_ADDR_W-1:0] avmm_addr_t;
	typedef logic [CL_ADDR_W-1:0]   cl_addr_t;
	typedef logic [LINE_DATA_W-1:0] line_data_t;
	typedef logic [BURST_W-1:0]     burst_t;
	typedef logic [MDATA_W-1:0]     mdata_t;
	typedef logic [IRQ_ID_W-1:0]    irq_id_t;

	// ************************************************************
	// encodings, kept at the CCI-P values
	// ************************************************************

	// number of lines carried by one write request
	typedef enum logic [1:0] {
		CL_LEN_1 = 2'b00,
		CL_LEN_2 = 2'b01,
		CL_LEN_4 = 2'b11
	} cl_len_e;

	typedef enum logic [3:0] {
		REQ_WRLINE  = 4'h0,
		REQ_WRFENCE = 4'h4,
		REQ_INTR    = 4'h6
	} req_type_e;

	typedef enum logic [3:0] {
		RSP_WRLINE  = 4'h0,
		RSP_WRFENCE = 4'h4,
		RSP_INTR    = 4'h6
	} rsp_type_e;

	// ************************************************************
	// channel 1 structs
	// ************************************************************

	// request header, mdata sits in the low bits like on the real channel
	typedef struct packed {
		req_type_e req_type;
		cl_len_e   cl_len;
		logic      sop;
		cl_addr_t  address;
		mdata_t    mdata;
	} c1_req_hdr_t;

	typedef struct packed {
		logic        valid;
		c1_req_hdr_t hdr;
		line_data_t  data;
	} c1_tx_t;

	typedef struct packed {
		logic      rsp_valid;
		rsp_type_e resp_type;
		mdata_t    mdata;
	} c1_rx_t;

	// what each source hands to the transmit port
	// the port fills in mdata, except for interrupts which carry their line id
	typedef struct packed {
		logic        valid;
		c1_req_hdr_t hdr;
		line_data_t  data;
	} src_req_t;

endpackage

`default_nettype wire
